/* ibex_shell_pkg.sv */
/*
  Shared widths, interrupt count and scramble defaults of the core shell,
  the scramble key state enum and the 7-bit bus integrity function
*/

`default_nettype none

package ibex_shell_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and integrity widths
  ////////////////////////////////////////////////////////////////////////////

  // Data word on instruction and data buses
  parameter int unsigned BusWidth = 32;

  // Integrity bits that travel alongside each bus word
  parameter int unsigned IntgWidth = 7;

  // Software, timer, external plus 15 fast lines
  parameter int unsigned NumIrq = 18;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction cache scrambling
  ////////////////////////////////////////////////////////////////////////////

  parameter int unsigned ScrKeyWidth   = 128;
  parameter int unsigned ScrNonceWidth = 64;

  // Values used until the key manager delivers a real key
  parameter logic [ScrKeyWidth-1:0] ScrKeyDefault =
      128'h3c9e_71a4_d02b_58f6_e1a7_0c93_4b6d_825f;
  parameter logic [ScrNonceWidth-1:0] ScrNonceDefault =
      64'h9f15_c3a8_62e0_7d4b;

  // Key state seen by the cache RAMs
  typedef enum logic {
    SCR_KEY_VALID = 1'b0,  // current key usable
    SCR_KEY_REQ   = 1'b1   // new key outstanding
  } scr_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bus integrity
  ////////////////////////////////////////////////////////////////////////////

  // Interleaved parity over the data word
  // Bit i covers every data bit whose index modulo IntgWidth equals i,
  // stored inverted so an all-zero word never carries all-zero integrity
  function automatic logic [IntgWidth-1:0] bus_intg(input logic [BusWidth-1:0] data);
    logic [IntgWidth-1:0] intg;
    intg = '1;
    for (int unsigned b = 0; b < BusWidth; b++) begin
      intg[b % IntgWidth] = intg[b % IntgWidth] ^ data[b];
    end
    return intg;
  endfunction

  // Group sizes with the current widths
  //   bits 0..3 cover five data bits each
  //   bits 4..6 cover four data bits each
  // Any single flipped bit in data or integrity changes the comparison

endpackage

`default_nettype wire

/* shell_wake_ctrl.sv */
/*
  Sleep control of the core shell: enabled interrupt reduction,
  registered core busy flag and the combinational sleep level
*/

`timescale 1ns/1ps
`default_nettype none

module shell_wake_ctrl #(
  parameter int unsigned NumIrq = ibex_shell_pkg::NumIrq
) (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              core_busy_i,
  input  logic              debug_req_i,
  input  logic [NumIrq-1:0] irq_i,
  input  logic [NumIrq-1:0] irq_en_i,
  input  logic              irq_nm_i,

  output logic              irq_pending_o,
  output logic              core_sleep_o
);

  logic core_busy_q;
  logic wake;

  // Any interrupt that is both raised and enabled
  assign irq_pending_o = |(irq_i & irq_en_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Clock enable of the core, sleep is its inverse
  assign wake         = core_busy_q | debug_req_i | irq_pending_o | irq_nm_i;
  assign core_sleep_o = ~wake;

  // An NMI must always keep the core clock running
  nmi_keeps_awake_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_nm_i |-> !core_sleep_o
  ) else $error("core_sleep_o high while irq_nm_i is pending");

endmodule

`default_nettype wire

/* bus_intg_check.sv */
/*
  Integrity check of read responses on the instruction and data buses
*/

`timescale 1ns/1ps
`default_nettype none

module bus_intg_check (
  // Instruction read response
  input  logic                                 instr_rvalid_i,
  input  logic [ibex_shell_pkg::BusWidth-1:0]  instr_rdata_i,
  input  logic [ibex_shell_pkg::IntgWidth-1:0] instr_rdata_intg_i,

  // Data read response
  input  logic                                 data_rvalid_i,
  input  logic [ibex_shell_pkg::BusWidth-1:0]  data_rdata_i,
  input  logic [ibex_shell_pkg::IntgWidth-1:0] data_rdata_intg_i,

  output logic                                 instr_intg_err_o,
  output logic                                 data_intg_err_o
);

  import ibex_shell_pkg::*;

  logic [IntgWidth-1:0] instr_intg_exp;
  logic [IntgWidth-1:0] data_intg_exp;
  logic                 instr_intg_mismatch;
  logic                 data_intg_mismatch;

  ////////////////////////////////////////////////////////////////////////////
  // Expected integrity
  ////////////////////////////////////////////////////////////////////////////

  assign instr_intg_exp = bus_intg(instr_rdata_i);
  assign data_intg_exp  = bus_intg(data_rdata_i);

  // Any differing bit marks the response as corrupt
  assign instr_intg_mismatch = |(instr_intg_exp ^ instr_rdata_intg_i);
  assign data_intg_mismatch  = |(data_intg_exp ^ data_rdata_intg_i);

  ////////////////////////////////////////////////////////////////////////////
  // Error flags
  ////////////////////////////////////////////////////////////////////////////

  // Only valid beats count, idle bus contents are don't care
  assign instr_intg_err_o = instr_rvalid_i & instr_intg_mismatch;
  assign data_intg_err_o  = data_rvalid_i & data_intg_mismatch;

endmodule

`default_nettype wire

/* scramble_key_ctrl.sv */
/*
  Instruction cache scramble key control: two-state request FSM and the
  key and nonce registers loaded from the key manager
*/

`timescale 1ns/1ps
`default_nettype none

module scramble_key_ctrl #(
  parameter logic [ibex_shell_pkg::ScrKeyWidth-1:0]   DefaultKey   =
      ibex_shell_pkg::ScrKeyDefault,
  parameter logic [ibex_shell_pkg::ScrNonceWidth-1:0] DefaultNonce =
      ibex_shell_pkg::ScrNonceDefault
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,

  // Cache invalidation from the core
  input  logic                                     icache_inval_i,

  // Key manager side
  input  logic                                     scramble_key_valid_i,
  input  logic [ibex_shell_pkg::ScrKeyWidth-1:0]   scramble_key_i,
  input  logic [ibex_shell_pkg::ScrNonceWidth-1:0] scramble_nonce_i,
  output logic                                     scramble_req_o,

  // Towards the cache RAMs
  output logic                                     key_valid_o,
  output logic [ibex_shell_pkg::ScrKeyWidth-1:0]   key_o,
  output logic [ibex_shell_pkg::ScrNonceWidth-1:0] nonce_o
);

  import ibex_shell_pkg::*;

  scr_state_e               state_q;
  scr_state_e               state_d;
  logic [ScrKeyWidth-1:0]   key_q;
  logic [ScrNonceWidth-1:0] nonce_q;

  ////////////////////////////////////////////////////////////////////////////
  // Key request FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      SCR_KEY_VALID: begin
        // Invalidation retires the current key
        if (icache_inval_i) begin
          state_d = SCR_KEY_REQ;
        end
      end
      SCR_KEY_REQ: begin
        // Request holds until the key manager answers
        if (scramble_key_valid_i) begin
          state_d = SCR_KEY_VALID;
        end
      end
      default: state_d = SCR_KEY_VALID;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SCR_KEY_VALID;
    end else begin
      state_q <= state_d;
    end
  end

  assign scramble_req_o = (state_q == SCR_KEY_REQ);
  assign key_valid_o    = (state_q == SCR_KEY_VALID);

  ////////////////////////////////////////////////////////////////////////////
  // Key and nonce capture
  ////////////////////////////////////////////////////////////////////////////

  // Any delivered key is taken, whatever the state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= DefaultKey;
      nonce_q <= DefaultNonce;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign key_o   = key_q;
  assign nonce_o = nonce_q;

  // Request and valid are mutually exclusive
  req_valid_onehot_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(scramble_req_o && key_valid_o)
  ) else $error("scramble_req_o and key_valid_o high together");

endmodule

`default_nettype wire

/* bus_alert_encode.sv */
/*
  Write data integrity generation and the registered major alerts
*/

`timescale 1ns/1ps
`default_nettype none

module bus_alert_encode (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  input  logic [ibex_shell_pkg::BusWidth-1:0]  data_wdata_i,
  input  logic                                 instr_intg_err_i,
  input  logic                                 data_intg_err_i,
  input  logic                                 core_alert_major_internal_i,

  output logic [ibex_shell_pkg::IntgWidth-1:0] data_wdata_intg_o,
  output logic                                 alert_major_bus_o,
  output logic                                 alert_major_internal_o
);

  import ibex_shell_pkg::*;

  logic alert_bus_q;
  logic alert_internal_q;

  // Same cycle as the write data
  assign data_wdata_intg_o = bus_intg(data_wdata_i);

  // One pulse per bad response, no stickiness
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_bus_q      <= 1'b0;
      alert_internal_q <= 1'b0;
    end else begin
      alert_bus_q      <= instr_intg_err_i | data_intg_err_i;
      alert_internal_q <= core_alert_major_internal_i;
    end
  end

  assign alert_major_bus_o      = alert_bus_q;
  assign alert_major_internal_o = alert_internal_q;

  // Failed read check from either channel reaches the alert one cycle later
  intg_err_to_alert_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (instr_intg_err_i || data_intg_err_i) |=> alert_major_bus_o
  ) else $error("integrity error not followed by alert_major_bus_o");

endmodule

`default_nettype wire

/* ibex_shell_top.sv */
/*
  Top level of the core security and power shell: wake control,
  read integrity check, scramble key control and alert encoding
*/

`timescale 1ns/1ps
`default_nettype none

module ibex_shell_top #(
  parameter logic [ibex_shell_pkg::ScrKeyWidth-1:0]   DefaultKey   =
      ibex_shell_pkg::ScrKeyDefault,
  parameter logic [ibex_shell_pkg::ScrNonceWidth-1:0] DefaultNonce =
      ibex_shell_pkg::ScrNonceDefault
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,

  // Wake sources and sleep
  input  logic                                     core_busy_i,
  input  logic                                     debug_req_i,
  input  logic [ibex_shell_pkg::NumIrq-1:0]        irq_i,
  input  logic [ibex_shell_pkg::NumIrq-1:0]        irq_en_i,
  input  logic                                     irq_nm_i,
  output logic                                     irq_pending_o,
  output logic                                     core_sleep_o,

  // Read responses
  input  logic                                     instr_rvalid_i,
  input  logic [ibex_shell_pkg::BusWidth-1:0]      instr_rdata_i,
  input  logic [ibex_shell_pkg::IntgWidth-1:0]     instr_rdata_intg_i,
  input  logic                                     data_rvalid_i,
  input  logic [ibex_shell_pkg::BusWidth-1:0]      data_rdata_i,
  input  logic [ibex_shell_pkg::IntgWidth-1:0]     data_rdata_intg_i,

  // Scramble key
  input  logic                                     icache_inval_i,
  input  logic                                     scramble_key_valid_i,
  input  logic [ibex_shell_pkg::ScrKeyWidth-1:0]   scramble_key_i,
  input  logic [ibex_shell_pkg::ScrNonceWidth-1:0] scramble_nonce_i,
  output logic                                     scramble_req_o,
  output logic                                     key_valid_o,
  output logic [ibex_shell_pkg::ScrKeyWidth-1:0]   key_o,
  output logic [ibex_shell_pkg::ScrNonceWidth-1:0] nonce_o,

  // Write integrity and alerts
  input  logic [ibex_shell_pkg::BusWidth-1:0]      data_wdata_i,
  input  logic                                     core_alert_major_internal_i,
  output logic [ibex_shell_pkg::IntgWidth-1:0]     data_wdata_intg_o,
  output logic                                     alert_major_bus_o,
  output logic                                     alert_major_internal_o
);

  import ibex_shell_pkg::*;

  // Check results towards the alert encoder
  logic instr_intg_err;
  logic data_intg_err;

  shell_wake_ctrl #(
    .NumIrq(NumIrq)
  ) u_shell_wake_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_i        (irq_i),
    .irq_en_i     (irq_en_i),
    .irq_nm_i     (irq_nm_i),
    .irq_pending_o(irq_pending_o),
    .core_sleep_o (core_sleep_o)
  );

  bus_intg_check u_bus_intg_check (
    .instr_rvalid_i    (instr_rvalid_i),
    .instr_rdata_i     (instr_rdata_i),
    .instr_rdata_intg_i(instr_rdata_intg_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_rdata_i      (data_rdata_i),
    .data_rdata_intg_i (data_rdata_intg_i),
    .instr_intg_err_o  (instr_intg_err),
    .data_intg_err_o   (data_intg_err)
  );

  scramble_key_ctrl #(
    .DefaultKey  (DefaultKey),
    .DefaultNonce(DefaultNonce)
  ) u_scramble_key_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .key_valid_o         (key_valid_o),
    .key_o               (key_o),
    .nonce_o             (nonce_o)
  );

  bus_alert_encode u_bus_alert_encode (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .data_wdata_i               (data_wdata_i),
    .instr_intg_err_i           (instr_intg_err),
    .data_intg_err_i            (data_intg_err),
    .core_alert_major_internal_i(core_alert_major_internal_i),
    .data_wdata_intg_o          (data_wdata_intg_o),
    .alert_major_bus_o          (alert_major_bus_o),
    .alert_major_internal_o     (alert_major_internal_o)
  );

endmodule

`default_nettype wire

/* tb_ibex_shell_cases.svh */
/*
  Stimulus table of the shell testbench: wake inputs, write and read words,
  corrupt flag and expected sleep level for each row
*/

`ifndef TB_IBEX_SHELL_CASES_SVH
`define TB_IBEX_SHELL_CASES_SVH

localparam int NumCases = 12;

string               case_name  [NumCases];
logic                case_busy  [NumCases];
logic                case_debug [NumCases];
logic [NumIrq-1:0]   case_irq   [NumCases];
logic [NumIrq-1:0]   case_en    [NumCases];
logic                case_nm    [NumCases];
logic [BusWidth-1:0] case_wdata [NumCases];
logic [BusWidth-1:0] case_rdata [NumCases];
logic                case_bad   [NumCases];
logic                case_sleep [NumCases];

task automatic set_case(input int i, input string name, input logic busy, input logic dbg,
                        input logic [NumIrq-1:0] irq, input logic [NumIrq-1:0] en,
                        input logic nm, input logic [BusWidth-1:0] wdata,
                        input logic [BusWidth-1:0] rdata, input logic bad, input logic sleep);
  case_name[i]  = name;
  case_busy[i]  = busy;
  case_debug[i] = dbg;
  case_irq[i]   = irq;
  case_en[i]    = en;
  case_nm[i]    = nm;
  case_wdata[i] = wdata;
  case_rdata[i] = rdata;
  case_bad[i]   = bad;
  case_sleep[i] = sleep;
endtask

task automatic build_cases();
  // idx, name, busy, debug, irq, irq_en, nmi, write word, read word, corrupt, sleep
  set_case( 0, "idle",         0, 0, 18'h00000, 18'h00000, 0, 32'h00000000, 32'h00000000, 0, 1);
  set_case( 1, "busy",         1, 0, 18'h00000, 18'h00000, 0, 32'hffffffff, 32'hffffffff, 1, 0);
  set_case( 2, "debug_req",    0, 1, 18'h00000, 18'h00000, 0, 32'h12345678, 32'h87654321, 0, 0);
  set_case( 3, "irq_masked",   0, 0, 18'h3ffff, 18'h00000, 0, 32'hdeadbeef, 32'hcafef00d, 1, 1);
  set_case( 4, "irq_timer",    0, 0, 18'h00080, 18'h00080, 0, 32'ha5a5a5a5, 32'h5a5a5a5a, 0, 0);
  set_case( 5, "irq_other",    0, 0, 18'h00008, 18'h00800, 0, 32'h0f0f0f0f, 32'hf0f0f0f0, 0, 1);
  set_case( 6, "irq_fast",     0, 0, 18'h20000, 18'h3ffff, 0, 32'h80000001, 32'h7ffffffe, 1, 0);
  set_case( 7, "nmi",          0, 0, 18'h00000, 18'h00000, 1, 32'h13579bdf, 32'h2468ace0, 0, 0);
  set_case( 8, "all_wake",     1, 1, 18'h3ffff, 18'h3ffff, 1, 32'h00ff00ff, 32'hff00ff00, 1, 0);
  set_case( 9, "busy_drop",    0, 0, 18'h00000, 18'h00000, 0, 32'h3c3c3c3c, 32'hc3c3c3c3, 0, 1);
  set_case(10, "single_bit",   0, 0, 18'h00000, 18'h00000, 0, 32'h00000001, 32'h80000000, 1, 1);
  set_case(11, "quiet",        0, 0, 18'h3ffff, 18'h00000, 0, 32'h7fffffff, 32'h55555555, 0, 1);
endtask

`endif

/* tb_ibex_shell.sv */
/*
  Testbench of the core shell: reset state, table driven wake and read
  integrity rows, random write words, internal alert and key refresh
*/

`timescale 1ns/1ps
`default_nettype none

module tb_ibex_shell;

  import ibex_shell_pkg::*;

  localparam int HalfPeriod = 20;
  localparam int DriveDelay = 2;

  logic                     clk_i, rst_ni;
  logic                     core_busy_i, debug_req_i, irq_nm_i, irq_pending_o, core_sleep_o;
  logic [NumIrq-1:0]        irq_i, irq_en_i;
  logic                     instr_rvalid_i, data_rvalid_i, icache_inval_i, scramble_key_valid_i;
  logic [BusWidth-1:0]      instr_rdata_i, data_rdata_i, data_wdata_i;
  logic [IntgWidth-1:0]     instr_rdata_intg_i, data_rdata_intg_i, data_wdata_intg_o;
  logic [ScrKeyWidth-1:0]   scramble_key_i, key_o;
  logic [ScrNonceWidth-1:0] scramble_nonce_i, nonce_o;
  logic                     scramble_req_o, key_valid_o, core_alert_major_internal_i;
  logic                     alert_major_bus_o, alert_major_internal_o;
  int                       errors;
  int                       checks;
  int unsigned              first_draw;

  `include "tb_ibex_shell_cases.svh"

  // Cycles of reset, table rows, random writes, alert pulse and key refresh with double margin
  localparam int WatchdogCycles = 2 * (3 + 2 * NumCases + 20 + 3 + 12);

  ibex_shell_top #(
    .DefaultKey  (ScrKeyDefault),
    .DefaultNonce(ScrNonceDefault)
  ) u_ibex_shell_top (.*);

  always #HalfPeriod clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////////////////////

  // Inverted parity of bits i, i+7, i+14 ... for each integrity bit
  function automatic logic [6:0] expected_intg(input logic [31:0] word);
    logic [6:0] intg;
    for (int i = 0; i < 7; i++) begin
      intg[i] = 1'b1;
      for (int j = i; j < 32; j += 7) begin
        intg[i] = intg[i] ^ word[j];
      end
    end
    return intg;
  endfunction

  // A line counts when it is both raised and enabled
  function automatic logic any_enabled_irq(input logic [NumIrq-1:0] irq,
                                           input logic [NumIrq-1:0] en);
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < NumIrq; k++) begin
      if (irq[k] && en[k]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Sleep only while every wake source is quiet
  function automatic logic sleep_rule(input logic busy_prev, input logic dbg,
                                      input logic [NumIrq-1:0] irq,
                                      input logic [NumIrq-1:0] en, input logic nm);
    return !(busy_prev || dbg || any_enabled_irq(irq, en) || nm);
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [127:0] exp, input logic [127:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s %s: expected %0h, actual %0h at %0t", test, what, exp, act, $time);
    end
  endtask

  task automatic to_drive_point();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////////////////////////////////////////

  // Each row takes two cycles
  // The read beat goes out in the first one and sleep and alert settle in the second
  task automatic run_table();
    logic [6:0] intg;
    logic       on_instr;
    logic       prev_busy;
    prev_busy = 1'b0;
    for (int i = 0; i < NumCases; i++) begin
      intg = expected_intg(case_rdata[i]);
      if (case_bad[i]) begin
        intg = intg ^ (7'b1 << ($urandom % 7));
      end
      on_instr = (i % 2 == 0);
      to_drive_point();
      core_busy_i        = case_busy[i];
      debug_req_i        = case_debug[i];
      irq_i              = case_irq[i];
      irq_en_i           = case_en[i];
      irq_nm_i           = case_nm[i];
      data_wdata_i       = case_wdata[i];
      instr_rvalid_i     = on_instr;
      instr_rdata_i      = case_rdata[i];
      instr_rdata_intg_i = intg;
      data_rvalid_i      = !on_instr;
      data_rdata_i       = case_rdata[i];
      data_rdata_intg_i  = intg;
      @(negedge clk_i);
      check_value(case_name[i], "wdata_intg", expected_intg(case_wdata[i]), data_wdata_intg_o);
      check_value(case_name[i], "bus_alert_before", 0, alert_major_bus_o);
      // Busy flag of the previous row still rules in this cycle
      check_value(case_name[i], "sleep_early",
                  sleep_rule(prev_busy, case_debug[i], case_irq[i], case_en[i], case_nm[i]),
                  core_sleep_o);
      to_drive_point();
      instr_rvalid_i = 1'b0;
      data_rvalid_i  = 1'b0;
      @(negedge clk_i);
      check_value(case_name[i], "sleep", case_sleep[i], core_sleep_o);
      check_value(case_name[i], "irq_pending", any_enabled_irq(case_irq[i], case_en[i]),
                  irq_pending_o);
      check_value(case_name[i], "bus_alert", case_bad[i], alert_major_bus_o);
      prev_busy = case_busy[i];
    end
  endtask

  task automatic random_writes();
    for (int n = 0; n < 20; n++) begin
      to_drive_point();
      data_wdata_i = $urandom;
      @(negedge clk_i);
      check_value("random_write", "wdata_intg", expected_intg(data_wdata_i), data_wdata_intg_o);
    end
  endtask

  task automatic internal_alert_pulse();
    to_drive_point();
    core_alert_major_internal_i = 1'b1;
    @(negedge clk_i);
    check_value("internal_alert", "same_cycle", 0, alert_major_internal_o);
    to_drive_point();
    core_alert_major_internal_i = 1'b0;
    @(negedge clk_i);
    check_value("internal_alert", "next_cycle", 1, alert_major_internal_o);
    @(negedge clk_i);
    check_value("internal_alert", "released", 0, alert_major_internal_o);
  endtask

  task automatic key_refresh();
    int unsigned      waits;
    logic [127:0]     key;
    logic [63:0]      nonce;
    waits = 1 + ($urandom % 8);
    key   = {$urandom, $urandom, $urandom, $urandom};
    nonce = {$urandom, $urandom};
    to_drive_point();
    icache_inval_i = 1'b1;
    to_drive_point();
    icache_inval_i = 1'b0;
    // Request holds while no key arrives
    for (int c = 0; c < waits; c++) begin
      @(negedge clk_i);
      check_value("key_refresh", "req_wait", 1, scramble_req_o);
      check_value("key_refresh", "valid_wait", 0, key_valid_o);
      check_value("key_refresh", "key_wait", ScrKeyDefault, key_o);
      to_drive_point();
    end
    scramble_key_i       = key;
    scramble_nonce_i     = nonce;
    scramble_key_valid_i = 1'b1;
    to_drive_point();
    scramble_key_valid_i = 1'b0;
    @(negedge clk_i);
    check_value("key_refresh", "req_done", 0, scramble_req_o);
    check_value("key_refresh", "valid_done", 1, key_valid_o);
    check_value("key_refresh", "key", key, key_o);
    check_value("key_refresh", "nonce", nonce, nonce_o);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    first_draw                  = $urandom(32'h5a821cc5);
    errors                      = 0;
    checks                      = 0;
    clk_i                       = 1'b0;
    rst_ni                      = 1'b0;
    core_busy_i                 = 1'b0;
    debug_req_i                 = 1'b0;
    irq_i                       = '0;
    irq_en_i                    = '0;
    irq_nm_i                    = 1'b0;
    instr_rvalid_i              = 1'b0;
    instr_rdata_i               = '0;
    instr_rdata_intg_i          = '0;
    data_rvalid_i               = 1'b0;
    data_rdata_i                = '0;
    data_rdata_intg_i           = '0;
    icache_inval_i              = 1'b0;
    scramble_key_valid_i        = 1'b0;
    scramble_key_i              = '0;
    scramble_nonce_i            = '0;
    data_wdata_i                = '0;
    core_alert_major_internal_i = 1'b0;
    build_cases();
    repeat (3) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("reset", "sleep", 1, core_sleep_o);
    check_value("reset", "scramble_req", 0, scramble_req_o);
    check_value("reset", "key_valid", 1, key_valid_o);
    check_value("reset", "key", ScrKeyDefault, key_o);
    check_value("reset", "nonce", ScrNonceDefault, nonce_o);
    check_value("reset", "bus_alert", 0, alert_major_bus_o);
    check_value("reset", "internal_alert", 0, alert_major_internal_o);
    run_table();
    random_writes();
    internal_alert_pulse();
    key_refresh();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * 2 * HalfPeriod);
    $display("Timeout: run still active after %0d clock cycles", WatchdogCycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* ibex_shell.f */
+incdir+.
ibex_shell_pkg.sv
shell_wake_ctrl.sv
bus_intg_check.sv
scramble_key_ctrl.sv
bus_alert_encode.sv
ibex_shell_top.sv
tb_ibex_shell.sv

/* Bender.yml */
package:
  name: ibex_shell

sources:
  - files:
      - ibex_shell_pkg.sv
      - shell_wake_ctrl.sv
      - bus_intg_check.sv
      - scramble_key_ctrl.sv
      - bus_alert_encode.sv
      - ibex_shell_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ibex_shell.sv
